/* logic/rsa_pkg.sv */
package rsa_pkg;

    // operand geometry
    localparam int key_bits      = 256;
    localparam int key_bytes     = 32;
    localparam int byte_idx_bits = 5;

    // serial port register map, byte addresses
    localparam logic [4:0] rx_addr     = 5'd0;
    localparam logic [4:0] tx_addr     = 5'd4;
    localparam logic [4:0] status_addr = 5'd8;

    // status register flags
    localparam int rx_ok_bit = 7;
    localparam int tx_ok_bit = 6;

    typedef enum logic [2:0] {
        get_n,
        get_d,
        get_data,
        calc,
        wait_calc,
        send_data
    } seq_state_e;

    typedef enum logic {
        poll,  // reading status until ready
        xfer   // moving one data byte
    } port_phase_e;

    typedef enum logic [2:0] {
        idle,
        prep,
        loop_mul,
        loop_sqr,
        finish
    } core_state_e;

endpackage

/* logic/rsa_avm_port.sv */
module rsa_avm_port
    import rsa_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  address,
    output logic        read,
    input  logic [31:0] readdata,
    output logic        write,
    output logic [31:0] writedata,
    input  logic        waitrequest,
    input  logic        rd_req,
    input  logic        wr_req,
    input  logic [7:0]  wr_byte,
    output logic        done,
    output logic [7:0]  rd_byte
);

    port_phase_e phase;
    logic        bus_ack;
    logic        go_rd;
    logic        go_wr;

    assign bus_ack = (read | write) & ~waitrequest;  // transfer completes this edge

    // ready bits only mean something on a completed status read
    assign go_rd = rd_req & readdata[rx_ok_bit];
    assign go_wr = wr_req & readdata[tx_ok_bit];

    assign done    = (phase == xfer) & bus_ack;
    assign rd_byte = readdata[7:0];  // sampled by the sequencer on done

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            phase   <= poll;
            address <= status_addr;
            read    <= 1'b1;
            write   <= 1'b0;
        end else begin
            case (phase)
                poll: begin
                    if (bus_ack) begin
                        if (go_rd) begin
                            phase   <= xfer;
                            address <= rx_addr;  // read stays high
                        end else if (go_wr) begin
                            phase   <= xfer;
                            address <= tx_addr;
                            read    <= 1'b0;
                            write   <= 1'b1;
                        end
                    end
                end
                xfer: begin
                    if (bus_ack) begin
                        // back to status polling for the next byte
                        phase   <= poll;
                        address <= status_addr;
                        read    <= 1'b1;
                        write   <= 1'b0;
                    end
                end
                default: phase <= poll;
            endcase
        end
    end

    // tx byte loaded on the way into a write xfer
    always_ff @(posedge avm_clk) begin
        if (phase == poll && bus_ack && !go_rd && go_wr) begin
            writedata <= {24'd0, wr_byte};
        end
    end

endmodule

/* logic/rsa_sequencer.sv */
module rsa_sequencer
    import rsa_pkg::*;
(
    input  logic                avm_clk,
    input  logic                avm_rst,
    output logic                rd_req,
    output logic                wr_req,
    output logic [7:0]          wr_byte,
    input  logic                done,
    input  logic [7:0]          rd_byte,
    output logic                core_start,
    output logic [key_bits-1:0] core_base,
    output logic [key_bits-1:0] core_exp,
    output logic [key_bits-1:0] core_mod,
    input  logic                core_finished,
    input  logic [key_bits-1:0] core_result
);

    seq_state_e               state;
    logic [byte_idx_bits-1:0] byte_cnt;  // wraps to 0 after byte 31
    logic                     last_byte;

    logic [key_bits-1:0] n_r;   // modulus
    logic [key_bits-1:0] d_r;   // private exponent
    logic [key_bits-1:0] ct_r;  // current ciphertext block
    logic [key_bits-1:0] pt_r;  // plaintext waiting to go out

    assign last_byte = (byte_cnt == byte_idx_bits'(key_bytes - 1));

    assign rd_req  = (state == get_n) || (state == get_d) || (state == get_data);
    assign wr_req  = (state == send_data);
    assign wr_byte = pt_r[8*byte_cnt +: 8];  // lsb first

    assign core_start = (state == calc);  // calc lasts exactly one cycle
    assign core_base  = ct_r;
    assign core_exp   = d_r;
    assign core_mod   = n_r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= get_n;
            byte_cnt <= '0;
        end else begin
            // done only comes back while a request is up
            if (done) begin
                byte_cnt <= byte_cnt + 1'b1;
            end
            case (state)
                get_n: begin
                    if (done && last_byte) begin
                        state <= get_d;
                    end
                end
                get_d: begin
                    if (done && last_byte) begin
                        state <= get_data;
                    end
                end
                get_data: begin
                    if (done && last_byte) begin
                        state <= calc;
                    end
                end
                calc: state <= wait_calc;
                wait_calc: begin
                    if (core_finished) begin
                        state <= send_data;
                    end
                end
                send_data: begin
                    if (done && last_byte) begin
                        state <= get_data;  // key stays loaded
                    end
                end
                default: state <= get_n;
            endcase
        end
    end

    // byte k lands in bits 8k and up
    always_ff @(posedge avm_clk) begin
        if (done) begin
            case (state)
                get_n:    n_r[8*byte_cnt +: 8]  <= rd_byte;
                get_d:    d_r[8*byte_cnt +: 8]  <= rd_byte;
                get_data: ct_r[8*byte_cnt +: 8] <= rd_byte;
                default: ;
            endcase
        end
        if (state == wait_calc && core_finished) begin
            pt_r <= core_result;
        end
    end

endmodule

/* logic/rsa_mod_prod.sv */
module rsa_mod_prod
    import rsa_pkg::*;
(
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] a,
    input  logic [key_bits-1:0] n,
    output logic                done,
    output logic [key_bits-1:0] result
);

    logic                        busy;
    logic [$clog2(key_bits)-1:0] iter;
    logic [key_bits-1:0]         r;    // running a*2^i mod n
    logic [key_bits:0]           dbl;  // one extra bit for the doubling
    logic [key_bits:0]           red;

    assign dbl    = {r, 1'b0};
    assign red    = dbl - {1'b0, n};
    assign result = r;

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            iter <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (iter == key_bits - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // r < n always holds, so 2r - n < n and one subtraction is enough
    always_ff @(posedge avm_clk) begin
        if (start) begin
            r <= a;
        end else if (busy) begin
            r <= (dbl >= {1'b0, n}) ? red[key_bits-1:0] : dbl[key_bits-1:0];
        end
    end

endmodule

/* logic/rsa_mont_mult.sv */
module rsa_mont_mult
    import rsa_pkg::*;
(
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] a,
    input  logic [key_bits-1:0] b,
    input  logic [key_bits-1:0] n,
    output logic                done,
    output logic [key_bits-1:0] result
);

    logic                        busy;
    logic [$clog2(key_bits)-1:0] iter;
    logic [key_bits-1:0]         a_sh;   // a, shifted right once per step
    logic [key_bits:0]           s;      // partial sum, stays below 2n
    logic [key_bits+1:0]         s_add;
    logic [key_bits+1:0]         s_odd;
    logic [key_bits:0]           s_half;
    logic [key_bits:0]           s_red;
    logic [key_bits:0]           s_fin;

    assign s_add  = {1'b0, s} + (a_sh[0] ? {2'b00, b} : '0);
    assign s_odd  = s_add + (s_add[0] ? {2'b00, n} : '0);  // make it even
    assign s_half = s_odd[key_bits+1:1];
    assign s_red  = s_half - {1'b0, n};
    assign s_fin  = (s_half >= {1'b0, n}) ? s_red : s_half;

    assign result = s[key_bits-1:0];

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            busy <= 1'b0;
            iter <= '0;
            done <= 1'b0;
        end else begin
            done <= 1'b0;
            if (start) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (iter == key_bits - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // b and n are read live, the core holds them for the whole product
    always_ff @(posedge avm_clk) begin
        if (start) begin
            a_sh <= a;
            s    <= '0;
        end else if (busy) begin
            a_sh <= a_sh >> 1;
            s    <= (iter == key_bits - 1) ? s_fin : s_half;  // last step also reduces
        end
    end

endmodule

/* logic/rsa_core.sv */
module rsa_core
    import rsa_pkg::*;
(
    input  logic                avm_clk,
    input  logic                avm_rst,
    input  logic                start,
    input  logic [key_bits-1:0] base,
    input  logic [key_bits-1:0] exp,
    input  logic [key_bits-1:0] modulus,
    output logic                finished,
    output logic [key_bits-1:0] result
);

    core_state_e                 state;
    logic [$clog2(key_bits)-1:0] bit_idx;  // exponent bit being processed
    logic [key_bits-1:0]         acc;      // partial result, montgomery form
    logic [key_bits-1:0]         sq;       // base^(2^i), montgomery form

    logic                prod_start;
    logic                base_done;
    logic                one_done;
    logic [key_bits-1:0] base_m;
    logic [key_bits-1:0] one_m;

    logic                mm_start;
    logic                mm_done;
    logic [key_bits-1:0] mm_a;
    logic [key_bits-1:0] mm_b;
    logic [key_bits-1:0] mm_res;

    assign prod_start = start && (state == idle);

    // shared multiplier operands
    assign mm_a = (state == loop_sqr) ? sq : acc;
    assign mm_b = (state == finish) ? key_bits'(1) : sq;  // times 1 leaves montgomery form

    assign finished = (state == finish) && mm_done;
    assign result   = mm_res;

    // base into montgomery form
    rsa_mod_prod base_prod_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prod_start),
        .a       (base),
        .n       (modulus),
        .done    (base_done),
        .result  (base_m)
    );

    // 2^256 mod n, the montgomery image of 1
    rsa_mod_prod one_prod_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (prod_start),
        .a       (key_bits'(1)),
        .n       (modulus),
        .done    (one_done),
        .result  (one_m)
    );

    rsa_mont_mult mult_i (
        .avm_clk (avm_clk),
        .avm_rst (avm_rst),
        .start   (mm_start),
        .a       (mm_a),
        .b       (mm_b),
        .n       (modulus),
        .done    (mm_done),
        .result  (mm_res)
    );

    always_ff @(posedge avm_clk or posedge avm_rst) begin
        if (avm_rst) begin
            state    <= idle;
            bit_idx  <= '0;
            mm_start <= 1'b0;
        end else begin
            mm_start <= 1'b0;
            case (state)
                idle: begin
                    if (prod_start) begin
                        state   <= prep;
                        bit_idx <= '0;
                    end
                end
                prep: begin
                    if (base_done) begin
                        state    <= exp[0] ? loop_mul : loop_sqr;
                        mm_start <= 1'b1;
                    end
                end
                loop_mul: begin
                    if (mm_done) begin
                        state    <= loop_sqr;
                        mm_start <= 1'b1;
                    end
                end
                loop_sqr: begin
                    if (mm_done) begin
                        mm_start <= 1'b1;
                        if (bit_idx == key_bits - 1) begin
                            state <= finish;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            state   <= exp[bit_idx + 1'b1] ? loop_mul : loop_sqr;
                        end
                    end
                end
                finish: begin
                    if (mm_done) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge avm_clk) begin
        case (state)
            prep: begin
                if (one_done) begin
                    acc <= one_m;
                end
                if (base_done) begin
                    sq <= base_m;
                end
            end
            loop_mul: begin
                if (mm_done) begin
                    acc <= mm_res;
                end
            end
            loop_sqr: begin
                if (mm_done) begin
                    sq <= mm_res;
                end
            end
            default: ;
        endcase
    end

endmodule

/* logic/rsa_top.sv */
module rsa_top
    import rsa_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    output logic [4:0]  address,
    output logic        read,
    input  logic [31:0] readdata,
    output logic        write,
    output logic [31:0] writedata,
    input  logic        waitrequest
);

    // byte handshake between port and sequencer
    logic       rd_req;
    logic       wr_req;
    logic [7:0] wr_byte;
    logic       done;
    logic [7:0] rd_byte;

    // sequencer to core
    logic                core_start;
    logic [key_bits-1:0] core_base;
    logic [key_bits-1:0] core_exp;
    logic [key_bits-1:0] core_mod;
    logic                core_finished;
    logic [key_bits-1:0] core_result;

    rsa_avm_port port_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .read        (read),
        .readdata    (readdata),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .rd_req      (rd_req),
        .wr_req      (wr_req),
        .wr_byte     (wr_byte),
        .done        (done),
        .rd_byte     (rd_byte)
    );

    rsa_sequencer seq_i (
        .avm_clk       (avm_clk),
        .avm_rst       (avm_rst),
        .rd_req        (rd_req),
        .wr_req        (wr_req),
        .wr_byte       (wr_byte),
        .done          (done),
        .rd_byte       (rd_byte),
        .core_start    (core_start),
        .core_base     (core_base),
        .core_exp      (core_exp),
        .core_mod      (core_mod),
        .core_finished (core_finished),
        .core_result   (core_result)
    );

    rsa_core core_i (
        .avm_clk  (avm_clk),
        .avm_rst  (avm_rst),
        .start    (core_start),
        .base     (core_base),
        .exp      (core_exp),
        .modulus  (core_mod),
        .finished (core_finished),
        .result   (core_result)
    );

endmodule

/* dv/uart_avm_model.sv */
module uart_avm_model
    import rsa_pkg::*;
(
    input  logic        avm_clk,
    input  logic        avm_rst,
    input  logic [4:0]  address,
    input  logic        read,
    output logic [31:0] readdata,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic        waitrequest,
    output int          tx_count
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] lfsr_seed = 32'h4b38b2e1;
    localparam logic [31:0] lfsr_taps = 32'h8020_0003;

    logic [7:0]  rx_q[$];  // bytes waiting to be read by the DUT
    logic [7:0]  tx_q[$];  // bytes written by the DUT
    logic [31:0] lfsr;

    // galois form, shifting right
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ lfsr_taps) : (s >> 1);
    endfunction

    task automatic push_rx(input logic [7:0] b);
        rx_q.push_back(b);
    endtask

    initial begin
        waitrequest = 1'b1;
        readdata    = '0;
        tx_count    = 0;
    end

    // waitrequest drops at least one cycle after a request shows up
    always @(posedge avm_clk or posedge avm_rst) begin
        logic [31:0] s;
        logic        rx_ok;
        logic        tx_ok;
        s = lfsr;
        if (avm_rst) begin
            waitrequest <= 1'b1;
            readdata    <= '0;
            tx_count    <= 0;
            lfsr        <= lfsr_seed;
        end else begin
            if (!waitrequest && (read || write)) begin
                // transfer completes on this edge
                if (read && address == rx_addr && rx_q.size() > 0) begin
                    void'(rx_q.pop_front());
                end
                if (write && address == tx_addr) begin
                    tx_q.push_back(writedata[7:0]);
                    tx_count <= tx_count + 1;
                end
                waitrequest <= 1'b1;
            end else if (read || write) begin
                s = lfsr_next(s);
                if (s[0]) begin
                    waitrequest <= 1'b0;
                    if (read && address == status_addr) begin
                        s = lfsr_next(s);
                        rx_ok = s[0] && (rx_q.size() > 0);  // never ready when empty
                        s = lfsr_next(s);
                        tx_ok = s[0];
                        readdata <= (32'(rx_ok) << rx_ok_bit) | (32'(tx_ok) << tx_ok_bit);
                    end else if (read && address == rx_addr) begin
                        readdata <= {24'd0, ((rx_q.size() > 0) ? rx_q[0] : 8'h00)};
                    end
                end
            end
            lfsr <= s;
        end
    end

endmodule

/* dv/tb_rsa_top.sv */
module tb_rsa_top
    import rsa_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_blocks     = 3;
    localparam int block_cycles   = 513 * 257 + 2000;
    localparam int timeout_cycles = num_blocks * block_cycles + 20000;

    localparam logic [key_bits-1:0] key_n =
        256'he7c3_5a91_0b4d_2f86_93ae_17c5_d260_4b8f_5e19_a7c3_08d2_6f4b_91e5_3c7a_2d80_b6f3;
    localparam logic [key_bits-1:0] key_d = '1;  // every exponent bit set

    logic        avm_clk;
    logic        avm_rst;
    logic [4:0]  address;
    logic        read;
    logic [31:0] readdata;
    logic        write;
    logic [31:0] writedata;
    logic        waitrequest;
    int          tx_count;

    logic [key_bits-1:0] ct [num_blocks];
    logic [key_bits-1:0] expected [num_blocks];

    logic        rst_q = 1'b0;
    logic [31:0] last_status = '0;  // latest completed status read
    int          rx_done = 0;
    int          cycle_cnt = 0;
    logic [38:0] bus_cmd;
    logic [38:0] bus_cmd_q;         // bus_cmd one cycle back
    int          fail_reset = 0;
    int          fail_stall = 0;
    int          fail_gate = 0;
    int          fail_order = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    rsa_top dut_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .read        (read),
        .readdata    (readdata),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest)
    );

    uart_avm_model uart_i (
        .avm_clk     (avm_clk),
        .avm_rst     (avm_rst),
        .address     (address),
        .read        (read),
        .readdata    (readdata),
        .write       (write),
        .writedata   (writedata),
        .waitrequest (waitrequest),
        .tx_count    (tx_count)
    );

    initial begin
        avm_clk = 1'b0;
        forever #5 avm_clk = ~avm_clk;
    end

    assign bus_cmd = {address, read, write, writedata};

    always @(posedge avm_clk) begin
        rst_q     <= avm_rst;
        bus_cmd_q <= bus_cmd;
        cycle_cnt <= cycle_cnt + 1;
        if (read && !waitrequest && address == status_addr) begin
            last_status <= readdata;
        end
        if (read && !waitrequest && address == rx_addr) begin
            rx_done <= rx_done + 1;
        end
    end

    reset_state_a: assert property (@(posedge avm_clk)
        rst_q |-> (read && !write && address == status_addr))
        else begin
            $display("[FAIL] reset bus state read=%h write=%h address=%h",
                     $sampled(read), $sampled(write), $sampled(address));
            fail_reset++;
        end

    stall_hold_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        $past(waitrequest) |-> bus_cmd === $past(bus_cmd))
        else begin
            $display("[FAIL] bus_cmd changed under waitrequest %h -> %h",
                     $sampled(bus_cmd_q), $sampled(bus_cmd));
            fail_stall++;
        end

    rx_gate_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (read && !waitrequest && address == rx_addr) |-> last_status[rx_ok_bit])
        else begin
            $display("rx register read although the last status read showed no rx data");
            fail_gate++;
        end

    tx_gate_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (write && !waitrequest && address == tx_addr) |-> last_status[tx_ok_bit])
        else begin
            $display("tx register written although the last status read showed tx busy");
            fail_gate++;
        end

    tx_order_a: assert property (@(posedge avm_clk) disable iff (avm_rst)
        (write && !waitrequest && address == tx_addr) |-> rx_done >= 3 * key_bytes)
        else begin
            $display("tx write happened before the first ciphertext was fully read");
            fail_order++;
        end

    // plain square and multiply with double width products
    function automatic logic [key_bits-1:0] ref_modexp(
        input logic [key_bits-1:0] base,
        input logic [key_bits-1:0] e,
        input logic [key_bits-1:0] m
    );
        logic [2*key_bits-1:0] r;
        logic [2*key_bits-1:0] b;
        r = 1;
        b = {{key_bits{1'b0}}, base} % m;
        for (int i = 0; i < key_bits; i++) begin
            if (e[i]) begin
                r = (r * b) % m;
            end
            b = (b * b) % m;
        end
        return r[key_bits-1:0];
    endfunction

    task automatic load_operand(input logic [key_bits-1:0] v);
        for (int k = 0; k < key_bytes; k++) begin
            uart_i.push_rx(v[8*k +: 8]);  // lsb first
        end
    endtask

    function automatic logic [key_bits-1:0] tx_block_word(input int blk);
        logic [key_bits-1:0] w;
        for (int k = 0; k < key_bytes; k++) begin
            w[8*k +: 8] = uart_i.tx_q[key_bytes*blk + k];
        end
        return w;
    endfunction

    task automatic report_test(input string name, input int errs);
        tests_run++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %s: %s (%0d errors)", name, (errs == 0) ? "ok" : "bad", errs);
    endtask

    // watchdog
    initial begin
        wait (cycle_cnt >= timeout_cycles);
        $display("timeout after %0d cycles, results did not all arrive", cycle_cnt);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        logic [key_bits-1:0] got;
        int                  fail_data;
        avm_rst = 1'b1;
        ct[0] = 256'h3a5f_9c01_7e2b_d448_06c9_b3e7_512a_8f6d_c470_19be_e53a_2d81_7f06_94cb_3e25_a1d7;
        ct[1] = 256'h0123_4567_89ab_cdef_fedc_ba98_7654_3210_0f1e_2d3c_4b5a_6978_8796_a5b4_c3d2_e1f0;
        ct[2] = '0;
        for (int blk = 0; blk < num_blocks; blk++) begin
            expected[blk] = ref_modexp(ct[blk], key_d, key_n);
        end

        // key first, then every block, the DUT pulls them as it goes
        load_operand(key_n);
        load_operand(key_d);
        for (int blk = 0; blk < num_blocks; blk++) begin
            load_operand(ct[blk]);
        end

        repeat (8) @(posedge avm_clk);
        avm_rst <= 1'b0;
        repeat (2) @(posedge avm_clk);
        report_test("reset_state", fail_reset);

        for (int blk = 0; blk < num_blocks; blk++) begin
            while (tx_count < key_bytes * (blk + 1)) begin
                @(posedge avm_clk);
            end
            got       = tx_block_word(blk);
            fail_data = 0;
            result_a: assert (got == expected[blk])
                else begin
                    $display("[FAIL] plaintext block %0d got=%h exp=%h", blk, got, expected[blk]);
                    fail_data = 1;
                end
            report_test($sformatf("block_%0d", blk), fail_data);
        end

        repeat (4) @(posedge avm_clk);
        report_test("stall_hold", fail_stall);
        report_test("ready_gate", fail_gate);
        report_test("tx_order", fail_order);
        $display("tests run %0d, failed %0d, cycles %0d", tests_run, tests_failed, cycle_cnt);
        if (tests_failed == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* sources.f */
logic/rsa_pkg.sv
logic/rsa_avm_port.sv
logic/rsa_sequencer.sv
logic/rsa_mod_prod.sv
logic/rsa_mont_mult.sv
logic/rsa_core.sv
logic/rsa_top.sv
dv/uart_avm_model.sv
dv/tb_rsa_top.sv

/* Bender.yml */
package:
  name: rsa_avm

sources:
  - logic/rsa_pkg.sv
  - logic/rsa_avm_port.sv
  - logic/rsa_sequencer.sv
  - logic/rsa_mod_prod.sv
  - logic/rsa_mont_mult.sv
  - logic/rsa_core.sv
  - logic/rsa_top.sv
  - target: test
    files:
      - dv/uart_avm_model.sv
      - dv/tb_rsa_top.sv
